//--- vlog.f
source/rob_pkg.sv
source/rob_pointers.sv
source/rob_entry_store.sv
source/rob_completion_track.sv
source/rob_retire_select.sv
source/rob_top.sv
sim/rob_tb.sv

//--- Bender.yml
package:
  name: rob

sources:
  - files:
      - source/rob_pkg.sv
      - source/rob_pointers.sv
      - source/rob_entry_store.sv
      - source/rob_completion_track.sv
      - source/rob_retire_select.sv
      - source/rob_top.sv
  - target: simulation
    files:
      - sim/rob_tb.sv

//--- sim/rob_tb.sv
`timescale 1ns/1ns

module rob_tb
	import rob_pkg::*;
();

	localparam int ROB_DEPTH = 16;
	localparam int NUM_CDB   = 6;
	localparam int WAIT_MAX  = 200; // cycles before a wait gives up

	typedef struct
	{
		pr_tag_t tag;
		pr_tag_t old_tag;
		ar_idx_t ar;
		logic    halt;
		logic    ready;
		logic    exc;
	} entry_t;

	logic                  clock;
	logic                  reset;
	slot_count_e           dispatch_num;
	pr_tag_t               dest_tag0, dest_tag1, old_tag0, old_tag1;
	ar_idx_t               dest_ar0, dest_ar1;
	logic                  valid_inst0, valid_inst1, halt0, halt1;
	slot_count_e           capacity;
	logic [NUM_CDB-1:0]    cdb_valid;
	pr_tag_t [NUM_CDB-1:0] cdb_tag;
	logic [NUM_CDB-1:0]    cdb_exception;
	slot_count_e           retire_num;
	ar_idx_t               retire_ar_a, retire_ar_b;
	pr_tag_t               retire_tag_a, retire_tag_b, retire_old_tag_a, retire_old_tag_b;
	logic                  recover_exception, retire_halt;

	entry_t  model_q[$]; // live entries in dispatch order
	int      seed = 32'h1fc1678a;
	int      err_count, pass_count, fail_count;
	int      retired_total, dispatched_total;
	int      seen_dual, seen_single, seen_exc, seen_halt;
	pr_tag_t tag_next;

	rob_top #(
		.ROB_DEPTH (ROB_DEPTH),
		.NUM_CDB   (NUM_CDB)
	) DUT (.*);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	task automatic check_count(input string name, input slot_count_e expected,
		input slot_count_e actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
			err_count++;
		end
	endtask

	task automatic check_tag(input string name, input pr_tag_t expected, input pr_tag_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
			err_count++;
		end
	endtask

	task automatic check_ar(input string name, input ar_idx_t expected, input ar_idx_t actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
			err_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
			err_count++;
		end
	endtask

	task automatic expect_event(input logic seen, input string what);
		if (!seen)
		begin
			$display("error: %s", what);
			err_count++;
		end
	endtask

	// in-order retire rule on the two oldest entries
	function automatic slot_count_e ref_retire(input entry_t a, input entry_t b, input int live,
		output logic exc, output logic halt);
		slot_count_e n;
		if (live >= 2 && a.ready && b.ready && !a.exc)
			n = SLOTS_TWO;
		else if (live >= 1 && a.ready)
			n = SLOTS_ONE; // excepting head leaves alone
		else
			n = SLOTS_NONE;
		exc  = (n != SLOTS_NONE && a.exc) || (n == SLOTS_TWO && b.exc);
		halt = (n != SLOTS_NONE && a.halt) || (n == SLOTS_TWO && b.halt);
		return n;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare process at mid-cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock)
	begin
		entry_t      a;
		entry_t      b;
		slot_count_e exp_n;
		slot_count_e exp_cap;
		logic        exp_exc;
		logic        exp_halt;
		if (!reset)
		begin
			a = '{default: '0};
			b = '{default: '0};
			if (model_q.size() > 0)
				a = model_q[0];
			if (model_q.size() > 1)
				b = model_q[1];
			exp_n = ref_retire(a, b, model_q.size(), exp_exc, exp_halt);
			if (model_q.size() == ROB_DEPTH)
				exp_cap = SLOTS_NONE; // full
			else if (model_q.size() == ROB_DEPTH - 1)
				exp_cap = SLOTS_ONE;
			else
				exp_cap = SLOTS_TWO;
			check_count("capacity", exp_cap, capacity);
			check_count("retire_num", exp_n, retire_num);
			check_bit("recover_exception", exp_exc, recover_exception);
			check_bit("retire_halt", exp_halt, retire_halt);
			if (exp_n != SLOTS_NONE)
			begin
				check_tag("retire_tag_a", a.tag, retire_tag_a);
				check_tag("retire_old_tag_a", a.old_tag, retire_old_tag_a);
				check_ar("retire_ar_a", a.ar, retire_ar_a);
			end
			if (exp_n == SLOTS_TWO)
			begin
				check_tag("retire_tag_b", b.tag, retire_tag_b);
				check_tag("retire_old_tag_b", b.old_tag, retire_old_tag_b);
				check_ar("retire_ar_b", b.ar, retire_ar_b);
			end
			seen_dual     += (retire_num == SLOTS_TWO);
			seen_single   += (retire_num == SLOTS_ONE);
			seen_exc      += recover_exception;
			seen_halt     += retire_halt;
			retired_total += int'(retire_num);
			repeat (int'(exp_n))
				void'(model_q.pop_front());
			for (int c = 0; c < NUM_CDB; c++)
				if (cdb_valid[c])
					foreach (model_q[i])
						if (model_q[i].tag == cdb_tag[c])
						begin
							model_q[i].ready = 1'b1;
							model_q[i].exc   = cdb_exception[c];
						end
			// halts and non-instructions have nothing to wait for
			if (dispatch_num != SLOTS_NONE)
				model_q.push_back('{dest_tag0, old_tag0, dest_ar0, halt0, halt0 | ~valid_inst0, 1'b0});
			if (dispatch_num == SLOTS_TWO)
				model_q.push_back('{dest_tag1, old_tag1, dest_ar1, halt1, halt1 | ~valid_inst1, 1'b0});
			dispatched_total += int'(dispatch_num);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers driving 2 ns after the rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clock);
		#2;
		dispatch_num  = SLOTS_NONE;
		cdb_valid     = '0;
		cdb_exception = '0;
	endtask

	task automatic set_lane(input int lane, input logic vi, input logic halt);
		pr_tag_t t;
		t = tag_next;
		tag_next = (tag_next == 7'd126) ? 7'd0 : tag_next + 7'd1; // skip the empty-slot tag
		if (lane == 0)
		begin
			dest_tag0   = t;
			old_tag0    = pr_tag_t'($random(seed));
			dest_ar0    = ar_idx_t'($random(seed));
			valid_inst0 = vi;
			halt0       = halt;
		end
		else
		begin
			dest_tag1   = t;
			old_tag1    = pr_tag_t'($random(seed));
			dest_ar1    = ar_idx_t'($random(seed));
			valid_inst1 = vi;
			halt1       = halt;
		end
	endtask

	task automatic wait_capacity(input int n);
		int waited;
		waited = 0;
		while (int'(capacity) < n && waited < WAIT_MAX)
		begin
			next_cycle();
			waited++;
		end
		if (int'(capacity) < n)
		begin
			$display("timeout: capacity never reached %0d free slots", n);
			err_count++;
		end
	endtask

	task automatic dispatch_entries(input int n, input logic vi, input logic halt);
		wait_capacity(n);
		set_lane(0, vi, halt);
		if (n == 2)
			set_lane(1, vi, halt);
		dispatch_num = slot_count_e'(n);
	endtask

	task automatic broadcast(input int port, input pr_tag_t tag, input logic exc);
		cdb_valid[port]     = 1'b1;
		cdb_tag[port]       = tag;
		cdb_exception[port] = exc;
	endtask

	// completes whatever is still pending until the buffer is empty
	task automatic drain();
		int waited;
		int port;
		waited = 0;
		do
		begin
			next_cycle();
			port = 0;
			foreach (model_q[i])
				if (!model_q[i].ready && port < NUM_CDB)
				begin
					broadcast(port, model_q[i].tag, 1'b0);
					port++;
				end
			waited++;
		end
		while (retired_total < dispatched_total && waited < WAIT_MAX);
		if (retired_total < dispatched_total)
		begin
			$display("timeout: buffer did not drain, %0d entries never retired",
				dispatched_total - retired_total);
			err_count++;
		end
	endtask

	task automatic end_test(input int num, input string name, input int errs_before);
		if (err_count == errs_before)
		begin
			pass_count++;
			$display("test %0d %s: ok", num, name);
		end
		else
		begin
			fail_count++;
			$display("test %0d %s: %0d errors", num, name, err_count - errs_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int base, n, idx, mark_a, mark_b;
		logic [ROB_DEPTH-1:0] used;
		pr_tag_t t;
		{err_count, pass_count, fail_count, retired_total, dispatched_total} = '0;
		{seen_dual, seen_single, seen_exc, seen_halt} = '0;
		tag_next = '0;
		reset = 1'b1;
		dispatch_num = SLOTS_NONE;
		{dest_tag0, dest_tag1, old_tag0, old_tag1, dest_ar0, dest_ar1} = '0;
		{valid_inst0, valid_inst1, halt0, halt1} = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		cdb_exception = '0;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;

		next_cycle();
		base = err_count;
		check_count("capacity", SLOTS_TWO, capacity);
		check_count("retire_num", SLOTS_NONE, retire_num);
		check_bit("recover_exception", 1'b0, recover_exception);
		check_bit("retire_halt", 1'b0, retire_halt);
		end_test(1, "reset values", base);

		base = err_count;
		t = tag_next;
		dispatch_entries(2, 1'b1, 1'b0);
		next_cycle();
		dispatch_entries(2, 1'b1, 1'b0);
		for (int k = 3; k >= 0; k--)
		begin
			next_cycle();
			broadcast(0, t + pr_tag_t'(k), 1'b0); // youngest completes first
		end
		drain();
		end_test(2, "in-order retire", base);

		base = err_count;
		mark_a = seen_dual;
		mark_b = seen_single;
		next_cycle();
		t = tag_next;
		dispatch_entries(2, 1'b1, 1'b0);
		next_cycle();
		dispatch_entries(1, 1'b0, 1'b0); // not an instruction
		broadcast(0, t + 7'd1, 1'b0);
		next_cycle();
		broadcast(2, t, 1'b0);
		drain();
		next_cycle();
		t = tag_next;
		dispatch_entries(2, 1'b1, 1'b0);
		next_cycle();
		broadcast(0, t, 1'b0); // head only
		next_cycle();
		next_cycle();
		drain();
		expect_event(seen_dual > mark_a, "no dual retire with both head entries ready");
		expect_event(seen_single > mark_b, "no single retire with only the head ready");
		end_test(3, "single and dual retire", base);

		base = err_count;
		mark_a = seen_exc;
		mark_b = seen_halt;
		next_cycle();
		t = tag_next;
		dispatch_entries(2, 1'b1, 1'b0);
		next_cycle();
		broadcast(0, t + 7'd1, 1'b0);
		next_cycle();
		broadcast(3, t, 1'b1); // head excepts
		drain();
		next_cycle();
		dispatch_entries(1, 1'b1, 1'b1);
		drain();
		expect_event(seen_exc > mark_a, "excepting head never raised recover_exception");
		expect_event(seen_halt > mark_b, "halt entry never raised retire_halt");
		end_test(4, "exception and halt", base);

		base = err_count;
		next_cycle();
		for (int k = 0; k < 7; k++)
		begin
			dispatch_entries(2, 1'b1, 1'b0);
			next_cycle();
		end
		dispatch_entries(1, 1'b1, 1'b0);
		next_cycle();
		check_count("capacity", SLOTS_ONE, capacity);
		dispatch_entries(1, 1'b1, 1'b0);
		next_cycle();
		check_count("capacity", SLOTS_NONE, capacity);
		drain();
		next_cycle();
		check_count("capacity", SLOTS_TWO, capacity);
		end_test(5, "capacity", base);

		base = err_count;
		for (int cyc = 0; cyc < 500; cyc++)
		begin
			next_cycle();
			n = $unsigned($random(seed)) % 3;
			if (n > int'(capacity))
				n = int'(capacity);
			for (int l = 0; l < n; l++)
				set_lane(l, ($random(seed) & 7) != 0, ($random(seed) & 31) == 0);
			dispatch_num = slot_count_e'(n);
			used = '0;
			for (int c = 0; c < NUM_CDB; c++)
				if (model_q.size() > 0 && ($random(seed) & 1) == 1)
				begin
					idx = $unsigned($random(seed)) % model_q.size();
					if (!used[idx] && !model_q[idx].ready)
					begin
						used[idx] = 1'b1; // one port per tag
						broadcast(c, model_q[idx].tag, ($random(seed) & 7) == 0);
					end
				end
		end
		drain();
		end_test(6, "random run", base);

		$display("tests passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- source/rob_top.sv
`timescale 1ns/1ns

module rob_top
	import rob_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int NUM_CDB   = 6
)
(
	input  logic                  clock,
	input  logic                  reset,
	// dispatch
	input  slot_count_e           dispatch_num,
	input  pr_tag_t               dest_tag0,
	input  pr_tag_t               dest_tag1,
	input  pr_tag_t               old_tag0,
	input  pr_tag_t               old_tag1,
	input  ar_idx_t               dest_ar0,
	input  ar_idx_t               dest_ar1,
	input  logic                  valid_inst0,
	input  logic                  valid_inst1,
	input  logic                  halt0,
	input  logic                  halt1,
	output slot_count_e           capacity,
	// completion
	input  logic [NUM_CDB-1:0]    cdb_valid,
	input  pr_tag_t [NUM_CDB-1:0] cdb_tag,
	input  logic [NUM_CDB-1:0]    cdb_exception,
	// retire
	output slot_count_e           retire_num,
	output ar_idx_t               retire_ar_a,
	output ar_idx_t               retire_ar_b,
	output pr_tag_t               retire_tag_a,
	output pr_tag_t               retire_tag_b,
	output pr_tag_t               retire_old_tag_a,
	output pr_tag_t               retire_old_tag_b,
	output logic                  recover_exception,
	output logic                  retire_halt
);

	localparam int PTR_W = $clog2(ROB_DEPTH);

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;

	// head views from the two slot modules
	logic    head_ready;
	logic    next_ready;
	logic    head_exception;
	logic    next_exception;
	pr_tag_t head_tag;
	pr_tag_t next_tag;
	pr_tag_t head_old_tag;
	pr_tag_t next_old_tag;
	ar_idx_t head_ar;
	ar_idx_t next_ar;
	logic    head_halt;
	logic    next_halt;

	rob_pointers #(
		.ROB_DEPTH (ROB_DEPTH)
	) u_pointers (
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.retire_num   (retire_num),
		.head         (head),
		.tail         (tail),
		.capacity     (capacity)
	);

	rob_entry_store #(
		.ROB_DEPTH (ROB_DEPTH)
	) u_entry_store (
		.clock        (clock),
		.reset        (reset),
		.dispatch_num (dispatch_num),
		.tail         (tail),
		.head         (head),
		.old_tag0     (old_tag0),
		.old_tag1     (old_tag1),
		.dest_ar0     (dest_ar0),
		.dest_ar1     (dest_ar1),
		.halt0        (halt0),
		.halt1        (halt1),
		.head_old_tag (head_old_tag),
		.next_old_tag (next_old_tag),
		.head_ar      (head_ar),
		.next_ar      (next_ar),
		.head_halt    (head_halt),
		.next_halt    (next_halt)
	);

	rob_completion_track #(
		.ROB_DEPTH (ROB_DEPTH),
		.NUM_CDB   (NUM_CDB)
	) u_completion_track (
		.clock          (clock),
		.reset          (reset),
		.dispatch_num   (dispatch_num),
		.tail           (tail),
		.head           (head),
		.retire_num     (retire_num),
		.dest_tag0      (dest_tag0),
		.dest_tag1      (dest_tag1),
		.valid_inst0    (valid_inst0),
		.valid_inst1    (valid_inst1),
		.halt0          (halt0),
		.halt1          (halt1),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_exception  (cdb_exception),
		.head_ready     (head_ready),
		.next_ready     (next_ready),
		.head_exception (head_exception),
		.next_exception (next_exception),
		.head_tag       (head_tag),
		.next_tag       (next_tag)
	);

	rob_retire_select u_retire_select (
		.head_ready        (head_ready),
		.next_ready        (next_ready),
		.head_exception    (head_exception),
		.next_exception    (next_exception),
		.head_tag          (head_tag),
		.next_tag          (next_tag),
		.head_old_tag      (head_old_tag),
		.next_old_tag      (next_old_tag),
		.head_ar           (head_ar),
		.next_ar           (next_ar),
		.head_halt         (head_halt),
		.next_halt         (next_halt),
		.retire_num        (retire_num),
		.retire_tag_a      (retire_tag_a),
		.retire_tag_b      (retire_tag_b),
		.retire_old_tag_a  (retire_old_tag_a),
		.retire_old_tag_b  (retire_old_tag_b),
		.retire_ar_a       (retire_ar_a),
		.retire_ar_b       (retire_ar_b),
		.recover_exception (recover_exception),
		.retire_halt       (retire_halt)
	);

endmodule

//--- source/rob_retire_select.sv
`timescale 1ns/1ns

module rob_retire_select
	import rob_pkg::*;
(
	input  logic        head_ready,
	input  logic        next_ready,
	input  logic        head_exception,
	input  logic        next_exception,
	input  pr_tag_t     head_tag,
	input  pr_tag_t     next_tag,
	input  pr_tag_t     head_old_tag,
	input  pr_tag_t     next_old_tag,
	input  ar_idx_t     head_ar,
	input  ar_idx_t     next_ar,
	input  logic        head_halt,
	input  logic        next_halt,
	output slot_count_e retire_num,
	output pr_tag_t     retire_tag_a,
	output pr_tag_t     retire_tag_b,
	output pr_tag_t     retire_old_tag_a,
	output pr_tag_t     retire_old_tag_b,
	output ar_idx_t     retire_ar_a,
	output ar_idx_t     retire_ar_b,
	output logic        recover_exception,
	output logic        retire_halt
);

	logic lane_a_go; // head leaves this cycle
	logic lane_b_go; // head plus one leaves too

	//////////////////////////////////////////////////////////////////////
	// retire decision
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (head_ready & next_ready & ~head_exception)
		begin
			retire_num = SLOTS_TWO;
		end
		else if (head_ready)
		begin
			retire_num = SLOTS_ONE; // excepting head goes alone
		end
		else
		begin
			retire_num = SLOTS_NONE;
		end
	end

	assign lane_a_go = (retire_num != SLOTS_NONE);
	assign lane_b_go = (retire_num == SLOTS_TWO);

	// flags only count for lanes that actually retire
	assign recover_exception = (lane_a_go & head_exception) | (lane_b_go & next_exception);
	assign retire_halt       = (lane_a_go & head_halt) | (lane_b_go & next_halt);

	assign retire_tag_a     = head_tag;
	assign retire_tag_b     = next_tag;
	assign retire_old_tag_a = head_old_tag;
	assign retire_old_tag_b = next_old_tag;
	assign retire_ar_a      = head_ar;
	assign retire_ar_b      = next_ar;

endmodule

//--- source/rob_completion_track.sv
`timescale 1ns/1ns

module rob_completion_track
	import rob_pkg::*;
#(
	parameter int ROB_DEPTH = 16,
	parameter int NUM_CDB   = 6
)
(
	input  logic                           clock,
	input  logic                           reset,
	input  slot_count_e                    dispatch_num,
	input  logic [$clog2(ROB_DEPTH)-1:0]   tail,
	input  logic [$clog2(ROB_DEPTH)-1:0]   head,
	input  slot_count_e                    retire_num,
	input  pr_tag_t                        dest_tag0,
	input  pr_tag_t                        dest_tag1,
	input  logic                           valid_inst0,
	input  logic                           valid_inst1,
	input  logic                           halt0,
	input  logic                           halt1,
	input  logic [NUM_CDB-1:0]             cdb_valid,
	input  pr_tag_t [NUM_CDB-1:0]          cdb_tag,
	input  logic [NUM_CDB-1:0]             cdb_exception,
	output logic                           head_ready,
	output logic                           next_ready,
	output logic                           head_exception,
	output logic                           next_exception,
	output pr_tag_t                        head_tag,
	output pr_tag_t                        next_tag
);

	localparam int PTR_W = $clog2(ROB_DEPTH);

	logic [ROB_DEPTH-1:0] valid;     // slot holds a live entry
	logic [ROB_DEPTH-1:0] ready;     // completed, may retire
	logic [ROB_DEPTH-1:0] exception;
	pr_tag_t              tag_mem [ROB_DEPTH];

	logic [NUM_CDB-1:0] cdb_hit [ROB_DEPTH]; // broadcast c matches slot i

	logic [PTR_W-1:0] tail_p1;
	logic [PTR_W-1:0] head_p1;

	assign tail_p1 = tail + PTR_W'(1);
	assign head_p1 = head + PTR_W'(1);

	//////////////////////////////////////////////////////////////////////
	// tag compare, every broadcast against every slot
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int i = 0; i < ROB_DEPTH; i++)
		begin
			for (int c = 0; c < NUM_CDB; c++)
			begin
				cdb_hit[i][c] = cdb_valid[c] & valid[i] & (cdb_tag[c] == tag_mem[i]);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// slot state update
	//////////////////////////////////////////////////////////////////////

	// later assignments win: complete, then retire, then dispatch
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid     <= '0;
			ready     <= '0;
			exception <= '0;
			for (int i = 0; i < ROB_DEPTH; i++)
			begin
				tag_mem[i] <= NULL_TAG;
			end
		end
		else
		begin
			for (int i = 0; i < ROB_DEPTH; i++)
			begin
				for (int c = 0; c < NUM_CDB; c++)
				begin
					if (cdb_hit[i][c])
					begin
						ready[i]     <= 1'b1;
						exception[i] <= cdb_exception[c]; // highest port wins
					end
				end
			end

			if (retire_num != SLOTS_NONE)
			begin
				valid[head]     <= 1'b0;
				ready[head]     <= 1'b0;
				exception[head] <= 1'b0;
				tag_mem[head]   <= NULL_TAG;
			end
			if (retire_num == SLOTS_TWO)
			begin
				valid[head_p1]     <= 1'b0;
				ready[head_p1]     <= 1'b0;
				exception[head_p1] <= 1'b0;
				tag_mem[head_p1]   <= NULL_TAG;
			end

			if (dispatch_num != SLOTS_NONE)
			begin
				valid[tail]     <= 1'b1;
				ready[tail]     <= halt0 | ~valid_inst0; // nothing to wait for
				exception[tail] <= 1'b0;
				tag_mem[tail]   <= dest_tag0;
			end
			if (dispatch_num == SLOTS_TWO)
			begin
				valid[tail_p1]     <= 1'b1;
				ready[tail_p1]     <= halt1 | ~valid_inst1;
				exception[tail_p1] <= 1'b0;
				tag_mem[tail_p1]   <= dest_tag1;
			end
		end
	end

	assign head_ready     = ready[head];
	assign next_ready     = ready[head_p1]; // low when slot is empty
	assign head_exception = exception[head];
	assign next_exception = exception[head_p1];
	assign head_tag       = tag_mem[head];
	assign next_tag       = tag_mem[head_p1];

endmodule

//--- source/rob_entry_store.sv
`timescale 1ns/1ns

module rob_entry_store
	import rob_pkg::*;
#(
	parameter int ROB_DEPTH = 16
)
(
	input  logic                           clock,
	input  logic                           reset,
	input  slot_count_e                    dispatch_num,
	input  logic [$clog2(ROB_DEPTH)-1:0]   tail,
	input  logic [$clog2(ROB_DEPTH)-1:0]   head,
	input  pr_tag_t                        old_tag0,
	input  pr_tag_t                        old_tag1,
	input  ar_idx_t                        dest_ar0,
	input  ar_idx_t                        dest_ar1,
	input  logic                           halt0,
	input  logic                           halt1,
	output pr_tag_t                        head_old_tag,
	output pr_tag_t                        next_old_tag,
	output ar_idx_t                        head_ar,
	output ar_idx_t                        next_ar,
	output logic                           head_halt,
	output logic                           next_halt
);

	localparam int PTR_W = $clog2(ROB_DEPTH);

	pr_tag_t              old_tag_mem [ROB_DEPTH]; // tag freed at retire
	ar_idx_t              ar_mem      [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] halt_mem;

	logic [PTR_W-1:0] tail_p1;
	logic [PTR_W-1:0] head_p1;
	logic             wr_lane0;
	logic             wr_lane1;

	assign tail_p1 = tail + PTR_W'(1); // wraps
	assign head_p1 = head + PTR_W'(1);

	// lane 0 goes first, lane 1 only on a dual dispatch
	assign wr_lane0 = (dispatch_num != SLOTS_NONE);
	assign wr_lane1 = (dispatch_num == SLOTS_TWO);

	//////////////////////////////////////////////////////////////////////
	// payload writes at the tail
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (wr_lane0)
		begin
			old_tag_mem[tail] <= old_tag0;
			ar_mem[tail]      <= dest_ar0;
		end
		if (wr_lane1)
		begin
			old_tag_mem[tail_p1] <= old_tag1;
			ar_mem[tail_p1]      <= dest_ar1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			halt_mem <= '0; // no stray halt out of reset
		end
		else
		begin
			if (wr_lane0)
			begin
				halt_mem[tail] <= halt0;
			end
			if (wr_lane1)
			begin
				halt_mem[tail_p1] <= halt1;
			end
		end
	end

	// head views, lane a and lane b
	assign head_old_tag = old_tag_mem[head];
	assign next_old_tag = old_tag_mem[head_p1];
	assign head_ar      = ar_mem[head];
	assign next_ar      = ar_mem[head_p1];
	assign head_halt    = halt_mem[head];
	assign next_halt    = halt_mem[head_p1];

endmodule

//--- source/rob_pointers.sv
`timescale 1ns/1ns

module rob_pointers
	import rob_pkg::*;
#(
	parameter int ROB_DEPTH = 16
)
(
	input  logic                           clock,
	input  logic                           reset,
	input  slot_count_e                    dispatch_num, // entries written this cycle
	input  slot_count_e                    retire_num,   // entries leaving this cycle
	output logic [$clog2(ROB_DEPTH)-1:0]   head,
	output logic [$clog2(ROB_DEPTH)-1:0]   tail,
	output slot_count_e                    capacity
);

	localparam int PTR_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = PTR_W + 1; // must hold ROB_DEPTH itself

	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(ROB_DEPTH);

	logic [CNT_W-1:0] count; // live entries

	//////////////////////////////////////////////////////////////////////
	// head, tail and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			tail  <= tail + PTR_W'(dispatch_num); // wraps, depth is a power of two
			head  <= head + PTR_W'(retire_num);
			count <= count + CNT_W'(dispatch_num) - CNT_W'(retire_num);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// capacity decode
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (count == DEPTH_CNT)
		begin
			capacity = SLOTS_NONE; // full
		end
		else if (count == DEPTH_CNT - CNT_W'(1))
		begin
			capacity = SLOTS_ONE; // one slot left
		end
		else
		begin
			capacity = SLOTS_TWO;
		end
	end

endmodule

//--- source/rob_pkg.sv
package rob_pkg;

	//////////////////////////////////////////////////////////////////////
	// shared types for the reorder buffer
	//////////////////////////////////////////////////////////////////////

	typedef logic [6:0] pr_tag_t; // physical register tag
	typedef logic [4:0] ar_idx_t; // architectural register index

	// one encoding for dispatch count, capacity and retire count
	typedef enum logic [1:0]
	{
		SLOTS_NONE = 2'd0,
		SLOTS_ONE  = 2'd1,
		SLOTS_TWO  = 2'd2
	} slot_count_e;

	// empty slots hold this tag so a broadcast never hits them
	localparam pr_tag_t NULL_TAG = 7'd127;

endpackage
